//--- fetch.f
source/fetch_pkg.sv
source/fetch_ctrl_regs.sv
source/fetch_pc.sv
source/fetch_predecode.sv
source/ifu_pipe.sv
source/fetch_top.sv
tests/fetch_props.sv
tests/tb_fetch.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= fetch.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_fetch.sv
module tb_fetch;

    localparam int          PKT_TIMEOUT = 40;       // idle cycles before giving up
    localparam logic [31:0] HOLD_CYCLES = 32'd12;   // credits held back until here

    // one scenario
    typedef struct packed {
        logic [31:0]           boot_pc;
        logic                  dual_en;
        logic                  rand_ret;      // 0 return at once, 1 hold then random gaps
        logic [31:0]           flush_at;      // cycle the flush is driven, 0 none
        logic [31:0]           flush_pc;
        logic [31:0]           n_pkts;
        fetch_pkg::fetch_pkt_t first;
    } row_t;

    logic                   clk;
    logic                   arst_n_i;
    logic                   cfg_we_i;
    logic                   cfg_addr_i;
    logic [31:0]            cfg_wdata_i;
    logic [31:0]            cfg_rdata_o;
    logic                   imem_req_o;
    logic [31:0]            imem_addr_o;
    fetch_pkg::fetch_word_u imem_rdata_i;
    logic                   flush_i;
    logic [31:0]            redirect_pc_i;
    logic                   credit_ret_i;
    fetch_pkg::fetch_pkt_t  pkt_o;
    integer                 seed;
    logic                   mem_req_q;    // request seen last cycle
    logic [31:0]            mem_addr_q;
    row_t                   rows [5];
    string                  row_name [5];

    fetch_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // word at a byte address, offsets 3 and 4 in each 32-byte block are backward branches
    function automatic logic [31:0] mem_inst(input logic [31:0] a);
        logic [31:0] h;
        h = a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_0f00;   // mixes the whole address
        case (a[4:2])
            3'd3, 3'd4: return {1'b1, h[30:7], 7'b110_0011};
            3'd6:       return {1'b0, h[30:7], 7'b110_0011};   // forward, not predicted
            default:    return {h[31:7], 7'b001_0011};         // op-imm
        endcase
    endfunction

    function automatic logic mem_bwd(input logic [31:0] a);
        return (a[4:2] == 3'd3) || (a[4:2] == 3'd4);
    endfunction

    function automatic fetch_pkg::fetch_pkt_t empty_pkt();
        fetch_pkg::fetch_pkt_t p;
        p       = '0;
        p.inst1 = fetch_pkg::INST_NOP;
        p.inst2 = fetch_pkg::INST_NOP;
        return p;
    endfunction

    // packet decode should see for a fetch at pc
    function automatic fetch_pkg::fetch_pkt_t exp_pkt(input logic [31:0] pc, input logic dual);
        fetch_pkg::fetch_pkt_t p;
        p       = empty_pkt();
        p.valid = 1'b1;
        p.inst1 = mem_inst(pc);
        p.addr1 = pc;
        p.pred1 = mem_bwd(pc);
        if (!pc[2] && dual) begin   // slot 2 only from an aligned line
            p.inst2 = mem_inst(pc + 32'd4);
            p.addr2 = pc + 32'd4;
            p.pred2 = mem_bwd(pc + 32'd4);
        end
        return p;
    endfunction

    function automatic row_t make_row(input logic [31:0] boot, input logic dual,
                                      input logic rnd, input logic [31:0] fl_at,
                                      input logic [31:0] fl_pc, input logic [31:0] n);
        row_t r;
        r.boot_pc     = boot;
        r.dual_en     = dual;
        r.rand_ret    = rnd;
        r.flush_at    = fl_at;
        r.flush_pc    = fl_pc;
        r.n_pkts      = n;
        r.first       = exp_pkt(boot, dual);
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pkt(input string name, input fetch_pkg::fetch_pkt_t exp,
                             input fetch_pkg::fetch_pkt_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic apply_reset();
        arst_n_i      = 1'b0;
        cfg_we_i      = 1'b0;
        cfg_addr_i    = 1'b0;
        cfg_wdata_i   = '0;
        flush_i       = 1'b0;
        redirect_pc_i = '0;
        credit_ret_i  = 1'b0;
        repeat (3) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
    endtask

    task automatic cfg_write(input logic addr, input logic [31:0] data);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(negedge clk);
        cfg_we_i = 1'b0;   // address stays for read-back
    endtask

    // imem, answers the request of the previous cycle
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_req_q  <= 1'b0;
            mem_addr_q <= '0;
        end else begin
            mem_req_q  <= imem_req_o;
            mem_addr_q <= imem_addr_o;
        end
    end

    initial begin
        imem_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (mem_req_q) imem_rdata_i.raw = {mem_inst(mem_addr_q + 32'd4), mem_inst(mem_addr_q)};
            else           imem_rdata_i.raw = '0;
        end
    end

    task automatic run_row(input row_t r, input string name);
        logic [31:0] exp_pc;
        logic [31:0] count;
        logic [31:0] cyc;
        logic [31:0] flush_cyc;
        logic        flushed;
        int          pending;   // packets not yet credited back
        int          idle;
        apply_reset();
        check_pkt({name, " reset packet"}, empty_pkt(), pkt_o);
        check_word({name, " ctrl after reset"}, 32'h0, cfg_rdata_o);
        cfg_addr_i = 1'b1;
        @(negedge clk);
        check_word({name, " boot_pc after reset"}, 32'h0, cfg_rdata_o);
        cfg_write(1'b1, r.boot_pc);
        check_word({name, " boot_pc"}, r.boot_pc, cfg_rdata_o);
        cfg_write(1'b0, {30'b0, r.dual_en, 1'b1});   // fetch_en rises
        check_word({name, " ctrl"}, {30'b0, r.dual_en, 1'b1}, cfg_rdata_o);
        exp_pc    = r.boot_pc;
        count     = '0;
        cyc       = '0;
        flush_cyc = '0;
        flushed   = 1'b0;
        pending   = 0;
        idle      = 0;
        while (count < r.n_pkts) begin
            if (flushed && (cyc == flush_cyc + 32'd1 || cyc == flush_cyc + 32'd2)) begin
                check_pkt({name, " killed packet"}, empty_pkt(), pkt_o);
            end
            if (pkt_o.valid) begin
                check_pkt(name, (count == 0) ? r.first : exp_pkt(exp_pc, r.dual_en), pkt_o);
                exp_pc  = exp_pc[2] ? exp_pc + 32'd4 : exp_pc + 32'd8;
                count   = count + 32'd1;
                pending = pending + 1;
                idle    = 0;
            end else begin
                idle = idle + 1;
                if (idle > PKT_TIMEOUT) begin
                    abort_run($sformatf("%s: no packet from the DUT for %0d cycles", name, idle));
                end
            end
            if (r.rand_ret && cyc == HOLD_CYCLES) begin
                check_word({name, " packets without credits"},
                           32'(fetch_pkg::FETCH_CREDITS), count);
            end
            credit_ret_i = 1'b0;
            if (pending > 0 &&
                (!r.rand_ret || (cyc > HOLD_CYCLES && ($random(seed) & 3) == 0))) begin
                credit_ret_i = 1'b1;
                pending      = pending - 1;
            end
            flush_i = 1'b0;
            if (!flushed && r.flush_at != 0 && cyc == r.flush_at) begin
                flush_i       = 1'b1;
                redirect_pc_i = r.flush_pc;
                flush_cyc     = cyc;
                flushed       = 1'b1;
                exp_pc        = r.flush_pc;   // fetch restarts here
            end
            cyc = cyc + 32'd1;
            @(negedge clk);
        end
        credit_ret_i = 1'b0;
        flush_i      = 1'b0;
    endtask

    initial begin
        seed          = 32'h98a5_5b5e;
        arst_n_i      = 1'b0;
        cfg_we_i      = 1'b0;
        cfg_addr_i    = 1'b0;
        cfg_wdata_i   = '0;
        flush_i       = 1'b0;
        redirect_pc_i = '0;
        credit_ret_i  = 1'b0;
        rows[0] = make_row(32'h0000_1000, 1'b1, 1'b0, 32'd0, 32'h0, 32'd12);
        rows[1] = make_row(32'h0000_2104, 1'b1, 1'b0, 32'd0, 32'h0, 32'd8);
        rows[2] = make_row(32'h0000_3000, 1'b0, 1'b0, 32'd0, 32'h0, 32'd8);
        rows[3] = make_row(32'h0000_4000, 1'b1, 1'b1, 32'd0, 32'h0, 32'd10);
        // flush lands while a response is due and a credit is free
        rows[4] = make_row(32'h0000_5000, 1'b1, 1'b0, 32'd5, 32'h0000_6004, 32'd10);
        row_name[0] = "aligned_dual";
        row_name[1] = "misaligned_boot";
        row_name[2] = "single_issue";
        row_name[3] = "credit_stall";
        row_name[4] = "flush_redirect";
        for (int i = 0; i < 5; i++) begin
            run_row(rows[i], row_name[i]);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- tests/fetch_props.sv
module fetch_props (
    input logic                           clk,
    input logic                           arst_n_i,
    input fetch_pkg::fetch_cfg_t          cfg_i,
    input logic                           flush_i,
    input logic                           credit_ret_i,   // decode drained a packet
    input logic                           rsp_valid_i,    // response due this cycle
    input logic                           req_i,      // fetch request to imem
    input logic [fetch_pkg::CREDIT_W-1:0] credit_i    // credit counter state
);

    int outst_q;   // requests not yet credited back, seen from the ports

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            outst_q <= 0;
        end else begin
            // a flushed response never reaches decode, its credit comes back here
            outst_q <= outst_q + int'(req_i) - int'(credit_ret_i)
                       - int'(flush_i & rsp_valid_i);
        end
    end

    // held credits plus packets out stay within decode depth
    a_credit_max: assert property (@(posedge clk) disable iff (!arst_n_i)
        int'(credit_i) + outst_q <= int'(fetch_pkg::FETCH_CREDITS))
        else $error("credit count above decode depth");

    // a request always spends a credit it has
    a_req_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_i |-> (outst_q < int'(fetch_pkg::FETCH_CREDITS)))
        else $error("fetch request issued with zero credits");

    // not while off, not on the enable edge either
    a_req_enabled: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_i |-> cfg_i.fetch_en && $past(cfg_i.fetch_en))
        else $error("fetch request issued while fetch is disabled");

endmodule

bind fetch_pc fetch_props u_props (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .cfg_i        (cfg_i),
    .flush_i      (flush_i),
    .credit_ret_i (credit_ret_i),
    .rsp_valid_i  (rsp_valid_o),
    .req_i        (imem_req_o),
    .credit_i     (credit_q)
);

//--- source/fetch_top.sv
module fetch_top (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    // config port
    input  logic                                  cfg_we_i,
    input  logic                                  cfg_addr_i,
    input  logic [fetch_pkg::INST_ADDR_WIDTH-1:0] cfg_wdata_i,
    output logic [fetch_pkg::INST_ADDR_WIDTH-1:0] cfg_rdata_o,
    // instruction memory
    output logic                                  imem_req_o,
    output logic [fetch_pkg::INST_ADDR_WIDTH-1:0] imem_addr_o,
    input  fetch_pkg::fetch_word_u                imem_rdata_i,
    // redirect
    input  logic                                  flush_i,
    input  logic [fetch_pkg::INST_ADDR_WIDTH-1:0] redirect_pc_i,
    // decode
    input  logic                                  credit_ret_i,
    output fetch_pkg::fetch_pkt_t                 pkt_o
);

    fetch_pkg::fetch_cfg_t                 cfg;
    logic                                  rsp_valid;
    logic                                  rsp_kill;
    logic [fetch_pkg::INST_ADDR_WIDTH-1:0] rsp_pc;
    logic                                  pred_lo;
    logic                                  pred_hi;

    fetch_ctrl_regs u_regs (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .cfg_o       (cfg)
    );

    fetch_pc u_pc (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .cfg_i         (cfg),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .credit_ret_i  (credit_ret_i),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .rsp_valid_o   (rsp_valid),
        .rsp_kill_o    (rsp_kill),
        .rsp_pc_o      (rsp_pc)
    );

    // flags straight off the bus, same cycle as the data
    fetch_predecode u_predec (
        .word_i    (imem_rdata_i),
        .pred_lo_o (pred_lo),
        .pred_hi_o (pred_hi)
    );

    ifu_pipe u_pipe (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .word_i    (imem_rdata_i),
        .pc_i      (rsp_pc),
        .pred_lo_i (pred_lo),
        .pred_hi_i (pred_hi),
        .valid_i   (rsp_valid),
        .flush_i   (rsp_kill),
        .dual_en_i (cfg.dual_en),
        .pkt_o     (pkt_o)
    );

endmodule

//--- source/ifu_pipe.sv
module ifu_pipe (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  fetch_pkg::fetch_word_u                word_i,      // imem response
    input  logic [fetch_pkg::INST_ADDR_WIDTH-1:0] pc_i,        // pc of that response
    input  logic                                  pred_lo_i,
    input  logic                                  pred_hi_i,
    input  logic                                  valid_i,
    input  logic                                  flush_i,     // kill from pc sequencer
    input  logic                                  dual_en_i,
    output fetch_pkg::fetch_pkt_t                 pkt_o
);

    fetch_pkg::fetch_pkt_t pkt_d;
    fetch_pkg::fetch_pkt_t pkt_q;
    logic                  live;         // response survives
    logic                  misaligned;   // pc[2], entry at hi half
    logic                  use_slot2;

    assign live       = valid_i & ~flush_i;
    assign misaligned = pc_i[2];
    assign use_slot2  = live & ~misaligned & dual_en_i;

    always_comb begin
        // default is an empty packet, nop in both slots
        pkt_d       = '0;
        pkt_d.inst1 = fetch_pkg::INST_NOP;
        pkt_d.inst2 = fetch_pkg::INST_NOP;
        pkt_d.valid = live;

        if (live) begin
            pkt_d.addr1 = pc_i;   // already points at the right half
            if (misaligned) begin
                pkt_d.inst1 = word_i.slot.hi;
                pkt_d.pred1 = pred_hi_i;
            end else begin
                pkt_d.inst1 = word_i.slot.lo;
                pkt_d.pred1 = pred_lo_i;
            end
        end

        // second issue slot, only the hi half of an aligned line
        if (use_slot2) begin
            pkt_d.inst2 = word_i.slot.hi;
            pkt_d.addr2 = {pc_i[fetch_pkg::INST_ADDR_WIDTH-1:3], 3'b100};
            pkt_d.pred2 = pred_hi_i;
        end
    end

    // decode always has room under credits, so load every cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pkt_q <= '0;
        end else begin
            pkt_q <= pkt_d;
        end
    end

    assign pkt_o = pkt_q;

endmodule

//--- source/fetch_predecode.sv
module fetch_predecode (
    input  fetch_pkg::fetch_word_u word_i,
    output logic                   pred_lo_o,   // slot at pc, aligned
    output logic                   pred_hi_o    // slot at pc+4
);

    // btfn: backward conditional branch is taken
    function automatic logic bwd_branch(input logic [fetch_pkg::INST_W-1:0] inst);
        logic is_br;
        is_br = (inst[6:0] == fetch_pkg::OPC_BRANCH);
        return is_br & inst[31];   // imm sign bit, negative offset
    endfunction

    // pure decode of the bus word, no state
    always_comb begin
        pred_lo_o = bwd_branch(word_i.slot.lo);
        pred_hi_o = bwd_branch(word_i.slot.hi);
    end

endmodule

//--- source/fetch_pc.sv
module fetch_pc (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  fetch_pkg::fetch_cfg_t                 cfg_i,
    input  logic                                  flush_i,        // redirect from backend
    input  logic [fetch_pkg::INST_ADDR_WIDTH-1:0] redirect_pc_i,
    input  logic                                  credit_ret_i,   // decode drained a packet
    output logic                                  imem_req_o,
    output logic [fetch_pkg::INST_ADDR_WIDTH-1:0] imem_addr_o,    // 8-byte aligned
    output logic                                  rsp_valid_o,    // imem data valid this cycle
    output logic                                  rsp_kill_o,     // drop this cycle's data
    output logic [fetch_pkg::INST_ADDR_WIDTH-1:0] rsp_pc_o        // full pc of that data
);

    logic [fetch_pkg::INST_ADDR_WIDTH-1:0] pc_q;
    logic [fetch_pkg::INST_ADDR_WIDTH-1:0] pc_d;
    logic [fetch_pkg::CREDIT_W-1:0]        credit_q;
    logic [fetch_pkg::CREDIT_W-1:0]        credit_d;
    logic [fetch_pkg::CREDIT_W:0]          credit_sum;   // one spare bit before clamp
    logic                                  en_q;         // fetch_en last cycle
    logic                                  start;        // fetch_en rising
    logic                                  req;
    logic                                  refund;       // in-flight fetch killed
    logic                                  infl_vld_q;
    logic [fetch_pkg::INST_ADDR_WIDTH-1:0] infl_pc_q;

    assign start  = cfg_i.fetch_en & ~en_q;
    // no fetch while boot pc loads or on a redirect, those would be wrong path
    assign req    = cfg_i.fetch_en & ~start & ~flush_i & (credit_q != '0);
    assign refund = flush_i & infl_vld_q;

    always_comb begin
        pc_d = pc_q;   // hold, also when out of credits
        if (flush_i) begin
            pc_d = redirect_pc_i;
        end else if (start) begin
            pc_d = cfg_i.boot_pc;
        end else if (req) begin
            // +8 when aligned, +4 from the hi half, both land on the next 8-byte line
            pc_d = {pc_q[fetch_pkg::INST_ADDR_WIDTH-1:3] + 1'b1, 3'b000};
        end
    end

    always_comb begin
        credit_sum = {1'b0, credit_q};
        if (credit_ret_i) credit_sum = credit_sum + 1'b1;
        if (refund)       credit_sum = credit_sum + 1'b1;
        if (req)          credit_sum = credit_sum - 1'b1;   // req implies credit_q > 0
        if (credit_sum > {1'b0, fetch_pkg::FETCH_CREDITS}) begin
            credit_d = fetch_pkg::FETCH_CREDITS;   // saturate at decode depth
        end else begin
            credit_d = credit_sum[fetch_pkg::CREDIT_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= '0;
            credit_q   <= fetch_pkg::FETCH_CREDITS;   // decode starts empty
            en_q       <= 1'b0;
            infl_vld_q <= 1'b0;
        end else begin
            pc_q       <= pc_d;
            credit_q   <= credit_d;
            en_q       <= cfg_i.fetch_en;
            infl_vld_q <= req;   // memory answers next cycle, always
        end
    end

    // pc of the outstanding fetch
    always_ff @(posedge clk) begin
        if (req) infl_pc_q <= pc_q;
    end

    assign imem_req_o  = req;
    assign imem_addr_o = {pc_q[fetch_pkg::INST_ADDR_WIDTH-1:3], 3'b000};
    assign rsp_valid_o = infl_vld_q;
    assign rsp_kill_o  = flush_i;   // whatever lands during a flush is stale
    assign rsp_pc_o    = infl_pc_q;

endmodule

//--- source/fetch_ctrl_regs.sv
module fetch_ctrl_regs (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  logic                                  cfg_we_i,     // write strobe
    input  logic                                  cfg_addr_i,   // 0 ctrl, 1 boot pc
    input  logic [fetch_pkg::INST_ADDR_WIDTH-1:0] cfg_wdata_i,
    output logic [fetch_pkg::INST_ADDR_WIDTH-1:0] cfg_rdata_o,
    output fetch_pkg::fetch_cfg_t                 cfg_o
);

    fetch_pkg::fetch_cfg_t cfg_q;

    // write side, one register per address
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_q <= '0;   // fetch off, single issue, boot at 0
        end else if (cfg_we_i) begin
            if (cfg_addr_i) begin
                cfg_q.boot_pc <= cfg_wdata_i;
            end else begin
                cfg_q.fetch_en <= cfg_wdata_i[0];
                cfg_q.dual_en  <= cfg_wdata_i[1];
            end
        end
    end

    // read-back is combinational, same cycle as the address
    always_comb begin
        if (cfg_addr_i) begin
            cfg_rdata_o = cfg_q.boot_pc;
        end else begin
            cfg_rdata_o    = '0;                // upper ctrl bits read zero
            cfg_rdata_o[0] = cfg_q.fetch_en;
            cfg_rdata_o[1] = cfg_q.dual_en;
        end
    end

    assign cfg_o = cfg_q;

endmodule

//--- source/fetch_pkg.sv
package fetch_pkg;

    // widths
    localparam int INST_ADDR_WIDTH = 32;   // pc and instruction address
    localparam int INST_W          = 32;   // one rv32 instruction
    localparam int CREDIT_W        = 2;    // credit counter bits

    // addi x0,x0,0
    localparam logic [INST_W-1:0] INST_NOP = 32'h0000_0013;

    // conditional branch major opcode
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

    // packets decode can hold, counter reset value
    localparam logic [CREDIT_W-1:0] FETCH_CREDITS = 2'd2;

    // two slots of one 64-bit fetch, hi is the word at pc+4
    typedef struct packed {
        logic [INST_W-1:0] hi;
        logic [INST_W-1:0] lo;
    } fetch_slots_t;

    // bus sees raw, predecode and pipe see slots
    typedef union packed {
        logic [2*INST_W-1:0] raw;
        fetch_slots_t        slot;
    } fetch_word_u;

    // packet handed to decode
    typedef struct packed {
        logic [INST_W-1:0]          inst1;
        logic [INST_ADDR_WIDTH-1:0] addr1;
        logic [INST_W-1:0]          inst2;
        logic [INST_ADDR_WIDTH-1:0] addr2;
        logic                       pred1;   // slot 1 predicted taken
        logic                       pred2;   // slot 2 predicted taken
        logic                       valid;
    } fetch_pkt_t;

    // config register contents
    typedef struct packed {
        logic                       fetch_en;
        logic                       dual_en;
        logic [INST_ADDR_WIDTH-1:0] boot_pc;
    } fetch_cfg_t;

endpackage
